/* source/vgaTimingPkg.sv */
`default_nettype none

package vgaTimingPkg;

	// pixel or line coordinate
	typedef logic [11:0] coordT;

	// frame counter, wraps every four frames
	typedef logic [1:0] fieldT;

	// vertical phases of one frame, in scan order
	typedef enum logic [1:0]
	{
		vActive,
		vFront,
		vSync,
		vBack
	} vStateT;

	// one scan position, handed down the pipeline with its pixel
	typedef struct packed
	{
		coordT x;
		coordT y;
		fieldT field;
		logic active;
		// raw sync levels, high inside the pulse
		logic hSync;
		logic vSync;
	} scanPosT;

endpackage

`default_nettype wire

/* source/vgaColorPkg.sv */
`default_nettype none

package vgaColorPkg;

	// one 8-bit color component
	typedef logic [7:0] chanT;

	// one 4-bit output component
	typedef logic [3:0] nibbleT;

	// position within the 4x4 dither cell
	typedef logic [3:0] bayerIdxT;

	typedef struct packed
	{
		chanT y;
		chanT u;
		chanT v;
	} yuvT;

	typedef struct packed
	{
		chanT r;
		chanT g;
		chanT b;
	} rgbT;

	// 12-bit pin-level color
	typedef struct packed
	{
		nibbleT r;
		nibbleT g;
		nibbleT b;
	} rgb4T;

	// level = (c * 160 + 20480) >> 8, gives 80..239
	localparam int levelGain = 160;
	localparam int levelOffset = 20480;

	// standard 4x4 Bayer thresholds, row-major
	localparam nibbleT bayerTab [16] = '{
		4'd0, 4'd8, 4'd2, 4'd10,
		4'd12, 4'd4, 4'd14, 4'd6,
		4'd3, 4'd11, 4'd1, 4'd9,
		4'd15, 4'd7, 4'd13, 4'd5
	};

endpackage

`default_nettype wire

/* source/vgaScanTimer.sv */
`timescale 1ns/1ns
`default_nettype none

module vgaScanTimer
#(
	parameter int hActive = 640,
	parameter int hFront = 16,
	parameter int hSync = 96,
	parameter int hBack = 48,
	parameter int vActive = 480,
	parameter int vFront = 10,
	parameter int vSync = 2,
	parameter int vBack = 33
)
(
	input wire clock,
	input wire rst,
	output vgaTimingPkg::scanPosT scanPos
);

	// clocks per line, all four horizontal phases
	localparam int lineLen = hActive + hFront + hSync + hBack;

	vgaTimingPkg::coordT hCount;
	// line within the current vertical phase
	vgaTimingPkg::coordT lineCount;
	vgaTimingPkg::coordT stateLines;
	vgaTimingPkg::vStateT vState;
	vgaTimingPkg::vStateT nextState;
	vgaTimingPkg::fieldT field;
	logic lineEnd;
	logic stateEnd;

	// length and successor of each vertical phase
	always_comb
	begin
		case (vState)
			vgaTimingPkg::vActive:
			begin
				stateLines = vgaTimingPkg::coordT'(vActive);
				nextState = vgaTimingPkg::vFront;
			end
			vgaTimingPkg::vFront:
			begin
				stateLines = vgaTimingPkg::coordT'(vFront);
				nextState = vgaTimingPkg::vSync;
			end
			vgaTimingPkg::vSync:
			begin
				stateLines = vgaTimingPkg::coordT'(vSync);
				nextState = vgaTimingPkg::vBack;
			end
			default:
			begin
				stateLines = vgaTimingPkg::coordT'(vBack);
				nextState = vgaTimingPkg::vActive;
			end
		endcase
	end

	assign lineEnd = (hCount == vgaTimingPkg::coordT'(lineLen - 1));
	assign stateEnd = (lineCount == stateLines - 1'b1);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			hCount <= '0;
			lineCount <= '0;
			vState <= vgaTimingPkg::vActive;
			field <= '0;
		end
		else if (lineEnd)
		begin
			hCount <= '0;
			if (stateEnd)
			begin
				lineCount <= '0;
				vState <= nextState;
				// last line of back porch closes the frame
				if (vState == vgaTimingPkg::vBack)
				begin
					field <= field + 1'b1;
				end
			end
			else
			begin
				lineCount <= lineCount + 1'b1;
			end
		end
		else
		begin
			hCount <= hCount + 1'b1;
		end
	end

	assign scanPos.x = hCount;
	assign scanPos.y = lineCount;
	assign scanPos.field = field;
	assign scanPos.active = (vState == vgaTimingPkg::vActive) &&
		(hCount < vgaTimingPkg::coordT'(hActive));
	// pulse starts after active area and front porch
	assign scanPos.hSync = (hCount >= vgaTimingPkg::coordT'(hActive + hFront)) &&
		(hCount < vgaTimingPkg::coordT'(hActive + hFront + hSync));
	assign scanPos.vSync = (vState == vgaTimingPkg::vSync);

	// line counter wraps before it reaches the line length
	hCountInLine: assert property (@(posedge clock) disable iff (rst)
		hCount < vgaTimingPkg::coordT'(lineLen));

endmodule

`default_nettype wire

/* source/yuvToRgb.sv */
`timescale 1ns/1ns
`default_nettype none

module yuvToRgb
(
	input wire clock,
	input wire rst,
	input wire pixValid,
	input wire vgaColorPkg::yuvT pixIn,
	input wire vgaTimingPkg::scanPosT scanPosIn,
	output logic pixReady,
	output vgaColorPkg::rgbT rgbOut,
	output logic presentOut,
	output vgaTimingPkg::scanPosT scanPosOut
);

	// signed intermediates, wide enough for the unclamped red and blue
	logic signed [11:0] lumaS;
	logic signed [11:0] uOffS;
	logic signed [11:0] vOffS;
	logic signed [11:0] greenS;
	logic signed [11:0] redS;
	logic signed [11:0] blueS;
	logic accept;

	function automatic vgaColorPkg::chanT clampChan(input logic signed [11:0] value);
		if (value < 0)
			return '0;
		else if (value > 255)
			return 8'hff;
		else
			return value[7:0];
	endfunction

	// one pixel per active clock, held off while in reset
	assign pixReady = scanPosIn.active && !rst;
	assign accept = pixValid && pixReady;

	assign lumaS = $signed({4'd0, pixIn.y});
	assign uOffS = $signed({4'd0, pixIn.u}) - 12'sd128;
	assign vOffS = $signed({4'd0, pixIn.v}) - 12'sd128;

	// shift-only conversion, halving rounds toward minus infinity
	assign greenS = lumaS - (uOffS >>> 1) - (vOffS >>> 1);
	assign redS = greenS + (vOffS <<< 1);
	assign blueS = greenS + (uOffS <<< 1);

	always_ff @(posedge clock)
	begin
		rgbOut.r <= clampChan(redS);
		rgbOut.g <= clampChan(greenS);
		rgbOut.b <= clampChan(blueS);
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			presentOut <= 1'b0;
			scanPosOut <= '0;
		end
		else
		begin
			// a bubble goes down as not present
			presentOut <= accept;
			scanPosOut <= scanPosIn;
		end
	end

	// a requested pixel travels on with an active position
	readyOnlyActive: assert property (@(posedge clock)
		pixReady |=> scanPosOut.active);

endmodule

`default_nettype wire

/* source/videoLevelScale.sv */
`timescale 1ns/1ns
`default_nettype none

module videoLevelScale
(
	input wire clock,
	input wire rst,
	input wire vgaColorPkg::rgbT rgbIn,
	input wire presentIn,
	input wire vgaTimingPkg::scanPosT scanPosIn,
	output vgaColorPkg::rgbT levelOut,
	output logic presentOut,
	output vgaTimingPkg::scanPosT scanPosOut
);

	// gain and offset map 0..255 onto 80..239
	function automatic vgaColorPkg::chanT scaleChan(input vgaColorPkg::chanT color);
		logic [15:0] product;
		product = 16'(color) * 16'(vgaColorPkg::levelGain) +
			16'(vgaColorPkg::levelOffset);
		return product[15:8];
	endfunction

	always_ff @(posedge clock)
	begin
		levelOut.r <= scaleChan(rgbIn.r);
		levelOut.g <= scaleChan(rgbIn.g);
		levelOut.b <= scaleChan(rgbIn.b);
	end

	// position and present flag keep step with the level
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			presentOut <= 1'b0;
			scanPosOut <= '0;
		end
		else
		begin
			presentOut <= presentIn;
			scanPosOut <= scanPosIn;
		end
	end

endmodule

`default_nettype wire

/* source/orderedDither.sv */
`timescale 1ns/1ns
`default_nettype none

module orderedDither
(
	input wire clock,
	input wire rst,
	input wire vgaColorPkg::rgbT levelIn,
	input wire presentIn,
	input wire vgaTimingPkg::scanPosT scanPosIn,
	output vgaColorPkg::rgb4T rgbOut,
	output logic hSyncN,
	output logic vSyncN
);

	vgaColorPkg::bayerIdxT ditherIdx;
	vgaColorPkg::nibbleT threshold;
	vgaColorPkg::rgb4T dithered;
	// registered active flag of the position on the pins
	logic activeQ;

	// round up when the dropped bits beat the threshold, no wrap at 15
	function automatic vgaColorPkg::nibbleT ditherChan(input vgaColorPkg::chanT level,
		input vgaColorPkg::nibbleT limit);
		vgaColorPkg::nibbleT upper;
		upper = level[7:4];
		if (level[3:0] > limit && upper != 4'hf)
			return upper + 4'd1;
		return upper;
	endfunction

	// field flips the cell so the pattern rotates frame by frame
	assign ditherIdx = {scanPosIn.y[1:0], scanPosIn.x[1:0]} ^
		{scanPosIn.field, scanPosIn.field};
	assign threshold = vgaColorPkg::bayerTab[ditherIdx];

	assign dithered.r = ditherChan(levelIn.r, threshold);
	assign dithered.g = ditherChan(levelIn.g, threshold);
	assign dithered.b = ditherChan(levelIn.b, threshold);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			rgbOut <= '0;
			hSyncN <= 1'b1;
			vSyncN <= 1'b1;
			activeQ <= 1'b0;
		end
		else
		begin
			activeQ <= scanPosIn.active;
			// pins are low-active
			hSyncN <= !scanPosIn.hSync;
			vSyncN <= !scanPosIn.vSync;
			// black for bubbles and for blanking
			if (presentIn && scanPosIn.active)
				rgbOut <= dithered;
			else
				rgbOut <= '0;
		end
	end

	// blanking is black on the pins
	blankIsBlack: assert property (@(posedge clock) disable iff (rst)
		!activeQ |-> rgbOut == '0);

endmodule

`default_nettype wire

/* source/vgaOut.sv */
`timescale 1ns/1ns
`default_nettype none

module vgaOut
#(
	parameter int hActive = 640,
	parameter int hFront = 16,
	parameter int hSync = 96,
	parameter int hBack = 48,
	parameter int vActive = 480,
	parameter int vFront = 10,
	parameter int vSync = 2,
	parameter int vBack = 33
)
(
	input wire clock,
	input wire rst,
	input wire pixValid,
	input wire vgaColorPkg::yuvT pixIn,
	output logic pixReady,
	output vgaTimingPkg::coordT reqX,
	output vgaTimingPkg::coordT reqY,
	output vgaTimingPkg::fieldT reqField,
	output vgaColorPkg::rgb4T rgbOut,
	output logic hSyncN,
	output logic vSyncN
);

	vgaTimingPkg::scanPosT scanPos;
	// stage 1 to stage 2
	vgaColorPkg::rgbT rgbConv;
	logic presentConv;
	vgaTimingPkg::scanPosT scanPosConv;
	// stage 2 to stage 3
	vgaColorPkg::rgbT rgbLevel;
	logic presentLevel;
	vgaTimingPkg::scanPosT scanPosLevel;

	vgaScanTimer #(
		.hActive(hActive),
		.hFront(hFront),
		.hSync(hSync),
		.hBack(hBack),
		.vActive(vActive),
		.vFront(vFront),
		.vSync(vSync),
		.vBack(vBack)
	) u_vgaScanTimer (
		.clock(clock),
		.rst(rst),
		.scanPos(scanPos)
	);

	// requested pixel is the one at the current scan position
	assign reqX = scanPos.x;
	assign reqY = scanPos.y;
	assign reqField = scanPos.field;

	yuvToRgb u_yuvToRgb (
		.clock(clock),
		.rst(rst),
		.pixValid(pixValid),
		.pixIn(pixIn),
		.scanPosIn(scanPos),
		.pixReady(pixReady),
		.rgbOut(rgbConv),
		.presentOut(presentConv),
		.scanPosOut(scanPosConv)
	);

	videoLevelScale u_videoLevelScale (
		.clock(clock),
		.rst(rst),
		.rgbIn(rgbConv),
		.presentIn(presentConv),
		.scanPosIn(scanPosConv),
		.levelOut(rgbLevel),
		.presentOut(presentLevel),
		.scanPosOut(scanPosLevel)
	);

	orderedDither u_orderedDither (
		.clock(clock),
		.rst(rst),
		.levelIn(rgbLevel),
		.presentIn(presentLevel),
		.scanPosIn(scanPosLevel),
		.rgbOut(rgbOut),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN)
	);

endmodule

`default_nettype wire

/* test/vgaOutChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module vgaOutChecker
#(
	parameter int hActive = 16,
	parameter int hFront = 4,
	parameter int hSync = 6,
	parameter int hBack = 4,
	parameter int vActive = 6,
	parameter int vFront = 2,
	parameter int vSync = 2,
	parameter int vBack = 2,
	parameter int frames = 3
)
(
	input wire clock,
	input wire rst,
	input wire pixValid,
	input wire vgaColorPkg::yuvT pixIn,
	input wire pixReady,
	input wire vgaTimingPkg::coordT reqX,
	input wire vgaTimingPkg::coordT reqY,
	input wire vgaTimingPkg::fieldT reqField,
	input wire vgaColorPkg::rgb4T rgbOut,
	input wire hSyncN,
	input wire vSyncN,
	output logic done,
	output int checkCount,
	output int errorCount
);

	localparam int lineLen = hActive + hFront + hSync + hBack;
	localparam int vTotal = vActive + vFront + vSync + vBack;
	localparam int frameLen = lineLen * vTotal;
	// clocks from acceptance to the pins
	localparam int depth = 3;

	localparam int tReset = 0;
	localparam int tColor = 1;
	localparam int tDither = 2;
	localparam int tBubble = 3;
	localparam int tBlank = 4;

	// Bayer thresholds, row-major over the 4x4 cell
	localparam int bayer [16] = '{0, 8, 2, 10, 12, 4, 14, 6, 3, 11, 1, 9, 15, 7, 13, 5};

	// what the pins should show a few clocks later
	typedef struct packed
	{
		int test;
		logic rotates;
		vgaColorPkg::rgb4T rgb;
		logic hSyncN;
		logic vSyncN;
	} expectT;

	expectT pipe [depth];
	expectT fresh;
	expectT due;
	int checks [5] = '{default: 0};
	int errors [5] = '{default: 0};
	int totalChecks = 0;
	int totalErrors = 0;
	logic finished = 1'b0;
	logic rotationSeen = 1'b0;
	int cycle;
	int pos;
	int line;
	int x;
	int frame;
	int field;
	logic active;
	int syncTest;
	int hsRun;
	int vsRun;
	int sinceHs;
	int hsPulses;
	int vsPulses;

	assign done = finished;
	assign checkCount = totalChecks;
	assign errorCount = totalErrors;

	// rounds toward minus infinity
	function automatic int halfDown(input int value);
		if (value < 0)
			return -((1 - value) / 2);
		return value / 2;
	endfunction

	function automatic int clamp8(input int value);
		if (value < 0)
			return 0;
		if (value > 255)
			return 255;
		return value;
	endfunction

	function automatic int levelOf(input int color);
		return (color * vgaColorPkg::levelGain + vgaColorPkg::levelOffset) / 256;
	endfunction

	// upper nibble, one more when the rest beats the threshold
	function automatic int ditherNibble(input int level, input int threshold);
		int coarse;
		coarse = level / 16;
		if (level % 16 > threshold && coarse != 15)
			coarse = coarse + 1;
		return coarse;
	endfunction

	// expected pins for one accepted pixel
	function automatic vgaColorPkg::rgb4T refPixel(input vgaColorPkg::yuvT pix, input int px,
		input int py, input int pf);
		int uOff;
		int vOff;
		int green;
		int red;
		int blue;
		int threshold;
		vgaColorPkg::rgb4T result;
		uOff = int'(pix.u) - 128;
		vOff = int'(pix.v) - 128;
		green = int'(pix.y) - halfDown(uOff) - halfDown(vOff);
		red = green + 2 * vOff;
		blue = green + 2 * uOff;
		// field picks a mirrored cell, {f,f} is f*5
		threshold = bayer[((py % 4) * 4 + (px % 4)) ^ (pf * 5)];
		result.r = 4'(ditherNibble(levelOf(clamp8(red)), threshold));
		result.g = 4'(ditherNibble(levelOf(clamp8(green)), threshold));
		result.b = 4'(ditherNibble(levelOf(clamp8(blue)), threshold));
		return result;
	endfunction

	function automatic string testName(input int test);
		case (test)
			tReset: return "reset";
			tColor: return "color path";
			tDither: return "dither rotation";
			tBubble: return "bubbles";
			default: return "blanking and sync";
		endcase
	endfunction

	task automatic tally(input int test, input logic ok);
		checks[test]++;
		totalChecks++;
		if (!ok)
		begin
			errors[test]++;
			totalErrors++;
		end
	endtask

	task automatic checkValue(input int test, input string name, input logic [31:0] expected,
		input logic [31:0] got);
		tally(test, got === expected);
		if (got !== expected)
			$display("mismatch %s expected %h got %h at cycle %0d", name, expected, got, cycle);
	endtask

	task automatic reportTest(input int test);
		if (errors[test] == 0)
			$display("test %s passed, %0d checks", testName(test), checks[test]);
		else
			$display("test %s failed, %0d of %0d checks wrong", testName(test), errors[test],
				checks[test]);
	endtask

	task automatic shiftPipe();
		for (int i = depth - 1; i > 0; i--)
			pipe[i] = pipe[i - 1];
	endtask

	// widths of the sync pulses on the pins
	task automatic watchSyncs();
		if (hSyncN === 1'b0)
		begin
			hsRun++;
			sinceHs = 0;
		end
		else
		begin
			if (hsRun != 0)
			begin
				tally(tBlank, hsRun == hSync);
				if (hsRun != hSync)
					$display("horizontal sync lasted %0d clocks instead of %0d", hsRun, hSync);
				hsPulses++;
			end
			hsRun = 0;
			sinceHs++;
			if (sinceHs == 2 * lineLen)
			begin
				tally(tBlank, 1'b0);
				$display("no horizontal sync pulse for two line lengths");
			end
		end
		if (vSyncN === 1'b0)
			vsRun++;
		else
		begin
			if (vsRun != 0)
			begin
				tally(tBlank, vsRun == vSync * lineLen);
				if (vsRun != vSync * lineLen)
					$display("vertical sync lasted %0d clocks instead of %0d", vsRun,
						vSync * lineLen);
				vsPulses++;
			end
			vsRun = 0;
		end
	endtask

	task automatic closeRun();
		tally(tBlank, hsPulses == frames * vTotal);
		if (hsPulses != frames * vTotal)
			$display("saw %0d horizontal sync pulses, wanted %0d", hsPulses, frames * vTotal);
		tally(tBlank, vsPulses == frames);
		if (vsPulses != frames)
			$display("saw %0d vertical sync pulses, wanted %0d", vsPulses, frames);
		tally(tDither, rotationSeen);
		if (!rotationSeen)
			$display("no gray pixel in field 1 showed the rotated dither cell");
		for (int t = tColor; t <= tBlank; t++)
			reportTest(t);
		finished = 1'b1;
	endtask

	// sampled mid-cycle, away from the rising edge
	always @(negedge clock)
	begin
		if (rst)
		begin
			cycle = 0;
			hsRun = 0;
			vsRun = 0;
			sinceHs = 0;
			hsPulses = 0;
			vsPulses = 0;
			checkValue(tReset, "pixReady", 32'(1'b0), 32'(pixReady));
			// pins are checked in the first clocks after release
			shiftPipe();
			pipe[0] = '0;
			pipe[0].test = tReset;
			pipe[0].hSyncN = 1'b1;
			pipe[0].vSyncN = 1'b1;
		end
		else if (!finished)
		begin
			// pins now carry the cycle pushed three clocks ago
			due = pipe[depth - 1];
			shiftPipe();
			checkValue(due.test, "rgbOut", 32'(due.rgb), 32'(rgbOut));
			syncTest = (due.test == tReset) ? tReset : tBlank;
			checkValue(syncTest, "hSyncN", 32'(due.hSyncN), 32'(hSyncN));
			checkValue(syncTest, "vSyncN", 32'(due.vSyncN), 32'(vSyncN));
			if (due.rotates && rgbOut === due.rgb)
				rotationSeen = 1'b1;
			watchSyncs();

			// own model of the raster, counted from reset release
			pos = cycle % frameLen;
			line = pos / lineLen;
			x = pos % lineLen;
			frame = cycle / frameLen;
			field = frame % 4;
			active = (line < vActive) && (x < hActive);
			checkValue(tBlank, "pixReady", 32'(active), 32'(pixReady));
			fresh = '0;
			fresh.test = tBlank;
			fresh.hSyncN = !((x >= hActive + hFront) && (x < hActive + hFront + hSync));
			fresh.vSyncN = !((line >= vActive + vFront) && (line < vActive + vFront + vSync));
			if (active)
			begin
				checkValue(tColor, "reqX", 32'(x), 32'(reqX));
				checkValue(tColor, "reqY", 32'(line), 32'(reqY));
				checkValue(tColor, "reqField", 32'(field), 32'(reqField));
				if (!pixValid)
					fresh.test = tBubble;
				else
				begin
					// odd lines of the first two frames carry the fixed gray
					fresh.test = (frame < 2 && line % 2 == 1) ? tDither : tColor;
					fresh.rgb = refPixel(pixIn, x, line, field);
					fresh.rotates = (field == 1) && (fresh.test == tDither) &&
						(fresh.rgb != refPixel(pixIn, x, line, 0));
				end
			end
			pipe[0] = fresh;
			cycle++;
			if (cycle == depth)
				reportTest(tReset);
			if (cycle == frames * frameLen + depth)
				closeRun();
		end
	end

endmodule

`default_nettype wire

/* test/vgaOutTb.sv */
`timescale 1ns/1ns
`default_nettype none

module vgaOutTb;

	// tiny raster so three frames stay short
	localparam int hActive = 16;
	localparam int hFront = 4;
	localparam int hSync = 6;
	localparam int hBack = 4;
	localparam int vActive = 6;
	localparam int vFront = 2;
	localparam int vSync = 2;
	localparam int vBack = 2;
	localparam int frames = 3;
	localparam int frameLen = (hActive + hFront + hSync + hBack) *
		(vActive + vFront + vSync + vBack);

	// level 0x97, its low nibble falls between Bayer thresholds
	localparam vgaColorPkg::yuvT grayPix = '{y: 8'h72, u: 8'h80, v: 8'h80};

	logic clock;
	logic rst;
	logic pixValid;
	vgaColorPkg::yuvT pixIn;
	logic pixReady;
	vgaTimingPkg::coordT reqX;
	vgaTimingPkg::coordT reqY;
	vgaTimingPkg::fieldT reqField;
	vgaColorPkg::rgb4T rgbOut;
	logic hSyncN;
	logic vSyncN;
	logic done;
	int checkCount;
	int errorCount;
	int tbErrors;
	integer seed;
	int rnd;

	vgaOut #(
		.hActive(hActive),
		.hFront(hFront),
		.hSync(hSync),
		.hBack(hBack),
		.vActive(vActive),
		.vFront(vFront),
		.vSync(vSync),
		.vBack(vBack)
	) u_vgaOut (
		.clock(clock),
		.rst(rst),
		.pixValid(pixValid),
		.pixIn(pixIn),
		.pixReady(pixReady),
		.reqX(reqX),
		.reqY(reqY),
		.reqField(reqField),
		.rgbOut(rgbOut),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN)
	);

	vgaOutChecker #(
		.hActive(hActive),
		.hFront(hFront),
		.hSync(hSync),
		.hBack(hBack),
		.vActive(vActive),
		.vFront(vFront),
		.vSync(vSync),
		.vBack(vBack),
		.frames(frames)
	) u_vgaOutChecker (
		.clock(clock),
		.rst(rst),
		.pixValid(pixValid),
		.pixIn(pixIn),
		.pixReady(pixReady),
		.reqX(reqX),
		.reqY(reqY),
		.reqField(reqField),
		.rgbOut(rgbOut),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.done(done),
		.checkCount(checkCount),
		.errorCount(errorCount)
	);

	// 4 ns period
	always #2 clock = ~clock;

	// pixel source, answers the request 1 ns after the edge
	always @(posedge clock)
	begin
		#1;
		rnd = $random(seed);
		if (reqField < 2'd2 && reqY[0])
		begin
			pixValid = 1'b1;
			pixIn = grayPix;
		end
		else
		begin
			// roughly one bubble in eight
			pixValid = (rnd[31:29] != 3'd0);
			pixIn = rnd[23:0];
		end
	end

	task automatic waitVSync();
		int cycles;
		cycles = 0;
		while (vSyncN === 1'b1 && cycles < 2 * frameLen)
		begin
			@(negedge clock);
			cycles++;
		end
		if (vSyncN !== 1'b0)
		begin
			$display("vertical sync never went low within two frames");
			tbErrors++;
		end
	endtask

	task automatic waitDone();
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles < (frames + 1) * frameLen)
		begin
			@(negedge clock);
			cycles++;
		end
		if (done !== 1'b1)
		begin
			$display("checker did not finish within %0d clocks", cycles);
			tbErrors++;
		end
	endtask

	initial
	begin
		// reset is up before the first clock level is set
		rst = 1'b1;
		clock = 1'b0;
		pixValid = 1'b0;
		pixIn = '0;
		tbErrors = 0;
		seed = 32'h7865_c554;
		repeat (5) @(posedge clock);
		#1;
		rst = 1'b0;
		waitVSync();
		waitDone();
		$display("%0d checks, %0d errors", checkCount, errorCount + tbErrors);
		if (tbErrors != 0 || errorCount != 0)
			$display("Simulation failed");
		else
			$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
source/vgaTimingPkg.sv
source/vgaColorPkg.sv
source/vgaScanTimer.sv
source/yuvToRgb.sv
source/videoLevelScale.sv
source/orderedDither.sv
source/vgaOut.sv
test/vgaOutChecker.sv
test/vgaOutTb.sv

/* Makefile */
# Verilator run of the VGA scan-out testbench

VERILATOR ?= verilator
TOP ?= vgaOutTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
